// File: logic/lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN   = 32;            // data and address width
  localparam int unsigned BE_W   = XLEN / 8;      // byte lanes per word
  localparam int unsigned OFFS_W = $clog2(BE_W);  // byte offset inside a word

  //////////////////////////////////////////////////////////////////////
  // opcodes and states
  //////////////////////////////////////////////////////////////////////

  // access size from the execute stage
  // 2'b11 is never driven, every decoder reads it as a byte
  typedef enum logic [1:0]
  {
    SIZE_WORD = 2'b00,  // 4 bytes
    SIZE_HALF = 2'b01,  // 2 bytes
    SIZE_BYTE = 2'b10   // 1 byte
  } mem_size_e;

  // controller states, the _2 pair is the second part of a split access
  typedef enum logic [2:0]
  {
    IDLE          = 3'd0,  // waiting for the execute stage
    WAIT_GNT      = 3'd1,  // first request out, no grant yet
    WAIT_RVALID   = 3'd2,  // first request granted
    WAIT_GNT_2    = 3'd3,  // second request out
    WAIT_RVALID_2 = 3'd4   // second request granted
  } lsu_state_e;

endpackage

// File: logic/lsu_ctrl_fsm.sv
`timescale 1ns/100ps

module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  // execute stage handshake
  input  logic req_i,           // request held by the execute stage
  output logic ready_o,         // free to accept, IDLE only
  output logic valid_o,         // one-cycle completion pulse
  output logic busy_o,          // a transaction is in flight

  // towards the request registers and data paths
  input  logic misaligned_i,    // captured access needs two parts
  output logic capture_o,       // latch the execute stage fields
  output logic second_o,        // second part of a split access
  output logic rvalid_first_o,  // first response of a split access

  // memory side
  output logic data_req_o,
  input  logic data_gnt_i,
  input  logic data_rvalid_i
);

  lsu_state_e state_q;  // current state
  lsu_state_e state_d;  // next state

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;  // hold unless an event arrives
    ready_o        = 1'b0;
    capture_o      = 1'b0;
    data_req_o     = 1'b0;
    second_o       = 1'b0;
    rvalid_first_o = 1'b0;
    valid_o        = 1'b0;

    case (state_q)
      IDLE:
      begin
        ready_o = 1'b1;  // combinational, no wait on memory
        if (req_i)
        begin
          capture_o = 1'b1;      // fields valid next cycle
          state_d   = WAIT_GNT;  // request goes out next cycle
        end
      end

      WAIT_GNT:
      begin
        data_req_o = 1'b1;  // held until the grant
        if (data_gnt_i)
        begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID:
      begin
        // no request here, one response still pending
        if (data_rvalid_i)
        begin
          if (misaligned_i)
          begin
            rvalid_first_o = 1'b1;        // load path keeps the first word
            state_d        = WAIT_GNT_2;
          end
          else
          begin
            valid_o = 1'b1;  // single part done
            state_d = IDLE;
          end
        end
      end

      WAIT_GNT_2:
      begin
        second_o   = 1'b1;  // next word address, upper byte lanes
        data_req_o = 1'b1;
        if (data_gnt_i)
        begin
          state_d = WAIT_RVALID_2;
        end
      end

      WAIT_RVALID_2:
      begin
        second_o = 1'b1;  // address and lanes stay on the second word
        if (data_rvalid_i)
        begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end

      default:
      begin
        state_d = IDLE;  // unused encodings fall back
      end
    endcase
  end

  assign busy_o = (state_q != IDLE);

endmodule

// File: logic/lsu_req_regs.sv
`timescale 1ns/100ps

module lsu_req_regs
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // request from the execute stage
  input  logic              capture_i,     // accept pulse from the FSM
  input  logic              we_i,
  input  mem_size_e         size_i,
  input  logic              sign_ext_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic              second_i,      // second part in progress

  // captured fields
  output logic              we_o,
  output mem_size_e         size_o,
  output logic              sign_ext_o,
  output logic [OFFS_W-1:0] offset_o,      // byte offset of the access
  output logic [XLEN-1:0]   wdata_o,
  output logic              misaligned_o,  // two memory parts needed
  output logic [XLEN-1:0]   data_addr_o    // address of the current part
);

  logic              we_q;
  mem_size_e         size_q;
  logic              sign_ext_q;
  logic [XLEN-1:0]   addr_q;
  logic [XLEN-1:0]   wdata_q;
  logic [XLEN-1:0]   addr_next;  // following word, aligned

  // control fields
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      we_q       <= 1'b0;
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
    end
    else if (capture_i)
    begin
      we_q       <= we_i;
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // address and store data
  always_ff @(posedge clk)
  begin
    if (capture_i)
    begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // word off a word boundary, or halfword in the last lane
  always_comb
  begin
    case (size_q)
      SIZE_WORD: misaligned_o = (addr_q[OFFS_W-1:0] != '0);
      SIZE_HALF: misaligned_o = (addr_q[OFFS_W-1:0] == '1);
      default:   misaligned_o = 1'b0;  // a byte never crosses a word
    endcase
  end

  assign addr_next   = {addr_q[XLEN-1:OFFS_W], {OFFS_W{1'b0}}} + XLEN'(BE_W);
  assign data_addr_o = second_i ? addr_next : addr_q;  // first part keeps the offset

  assign we_o       = we_q;
  assign size_o     = size_q;
  assign sign_ext_o = sign_ext_q;
  assign offset_o   = addr_q[OFFS_W-1:0];
  assign wdata_o    = wdata_q;

endmodule

// File: logic/lsu_store_path.sv
`timescale 1ns/100ps

module lsu_store_path
  import lsu_pkg::*;
(
  input  mem_size_e         size_i,        // captured access size
  input  logic [OFFS_W-1:0] offset_i,      // captured byte offset
  input  logic              second_i,      // second part of a split store
  input  logic [XLEN-1:0]   wdata_i,       // store data, byte 0 in bits 7:0
  output logic [BE_W-1:0]   data_be_o,
  output logic [XLEN-1:0]   data_wdata_o
);

  logic [BE_W-1:0]   be_base;  // lanes of the access at offset 0
  logic [2*BE_W-1:0] be_span;  // lanes over two adjacent words

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      SIZE_WORD: be_base = {BE_W{1'b1}};
      SIZE_HALF: be_base = BE_W'(2'b11);
      default:   be_base = BE_W'(1'b1);  // byte, 2'b11 included
    endcase
  end

  // lanes past 3 spill into the next word
  assign be_span = {{BE_W{1'b0}}, be_base} << offset_i;

  // first part takes the upper lanes of the first word,
  // second part the lower lanes of the next word
  assign data_be_o = second_i ? be_span[2*BE_W-1:BE_W] : be_span[BE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // write data lane rotation
  //////////////////////////////////////////////////////////////////////

  // byte k goes to lane (k + offset) mod 4
  // a split store finds its spilled bytes in the low lanes, so one
  // rotation serves both parts
  always_comb
  begin
    logic [OFFS_W-1:0] src_byte;  // source byte for this lane

    src_byte     = '0;
    data_wdata_o = '0;
    for (int lane = 0; lane < BE_W; lane++)
    begin
      src_byte = OFFS_W'(lane) - offset_i;  // wraps mod 4
      data_wdata_o[8*lane +: 8] = wdata_i[8*src_byte +: 8];
    end
  end

endmodule

// File: logic/lsu_load_path.sv
`timescale 1ns/100ps

module lsu_load_path
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rvalid_first_i,  // first response of a split load
  input  mem_size_e         size_i,          // captured access size
  input  logic              sign_ext_i,      // 1 sign, 0 zero extension
  input  logic [OFFS_W-1:0] offset_i,        // captured byte offset
  input  logic [XLEN-1:0]   data_rdata_i,    // current memory response
  output logic [XLEN-1:0]   rdata_o          // result to the execute stage
);

  logic [XLEN-1:0]   first_q;     // first word of a split load
  logic [OFFS_W:0]   num_bytes;   // bytes in the access
  logic              split;       // access spans two words
  logic [XLEN-1:0]   low_word;    // word holding lanes offset..3
  logic [2*XLEN-1:0] window;      // two words, lower one first
  logic [2*XLEN-1:0] shifted;     // window moved down by the offset
  logic [XLEN-1:0]   aligned;     // access bytes from bit 0 up

  //////////////////////////////////////////////////////////////////////
  // first part register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_q <= '0;
    end
    else if (rvalid_first_i)
    begin
      first_q <= data_rdata_i;  // bytes offset..3 are the low part
    end
  end

  //////////////////////////////////////////////////////////////////////
  // assembly
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      SIZE_WORD: num_bytes = (OFFS_W+1)'(4);
      SIZE_HALF: num_bytes = (OFFS_W+1)'(2);
      default:   num_bytes = (OFFS_W+1)'(1);
    endcase
  end

  // last byte beyond lane 3 means the access was split
  assign split = (({1'b0, offset_i} + num_bytes) > (OFFS_W+1)'(BE_W));

  // single part: all bytes sit in the current word from lane offset
  // split: low bytes in the stored word, high bytes in the current one
  assign low_word = split ? first_q : data_rdata_i;
  assign window   = {data_rdata_i, low_word};
  assign shifted  = window >> {offset_i, 3'b000};  // offset in bits
  assign aligned  = shifted[XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // size select and extension
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      SIZE_WORD:
      begin
        rdata_o = aligned;  // nothing to extend
      end
      SIZE_HALF:
      begin
        rdata_o = {{(XLEN-16){sign_ext_i & aligned[15]}}, aligned[15:0]};
      end
      default:
      begin
        rdata_o = {{(XLEN-8){sign_ext_i & aligned[7]}}, aligned[7:0]};
      end
    endcase
  end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // execute stage
  input  logic            req_i,
  input  logic            we_i,
  input  mem_size_e       size_i,
  input  logic            sign_ext_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            ready_o,
  output logic            valid_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            busy_o,

  // data memory
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic            data_err_i,     // only valid with the grant
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [BE_W-1:0] data_be_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic [XLEN-1:0] data_rdata_i,

  // bus errors
  output logic            load_err_o,
  output logic            store_err_o
);

  logic              capture;       // request accepted this cycle
  logic              second;        // second part of a split access
  logic              rvalid_first;  // first response of a split access
  logic              misaligned;
  logic              req_we;
  mem_size_e         req_size;
  logic              req_sign_ext;
  logic [OFFS_W-1:0] req_offset;
  logic [XLEN-1:0]   req_wdata;
  logic              gnt_err;       // grant carrying a bus error

  //////////////////////////////////////////////////////////////////////
  // submodules
  //////////////////////////////////////////////////////////////////////

  lsu_ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .busy_o         (busy_o),
    .misaligned_i   (misaligned),
    .capture_o      (capture),
    .second_o       (second),
    .rvalid_first_o (rvalid_first),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i)
  );

  lsu_req_regs u_req_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .capture_i    (capture),
    .we_i         (we_i),
    .size_i       (size_i),
    .sign_ext_i   (sign_ext_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .second_i     (second),
    .we_o         (req_we),
    .size_o       (req_size),
    .sign_ext_o   (req_sign_ext),
    .offset_o     (req_offset),
    .wdata_o      (req_wdata),
    .misaligned_o (misaligned),
    .data_addr_o  (data_addr_o)
  );

  lsu_store_path u_store_path (
    .size_i       (req_size),
    .offset_i     (req_offset),
    .second_i     (second),
    .wdata_i      (req_wdata),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o)
  );

  lsu_load_path u_load_path (
    .clk            (clk),
    .rst_n          (rst_n),
    .rvalid_first_i (rvalid_first),
    .size_i         (req_size),
    .sign_ext_i     (req_sign_ext),
    .offset_i       (req_offset),
    .data_rdata_i   (data_rdata_i),
    .rdata_o        (rdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // memory direction and error flags
  //////////////////////////////////////////////////////////////////////

  assign data_we_o = req_we;  // stable for the whole access

  // flagged in the grant cycle, direction from the captured request
  assign gnt_err     = data_req_o & data_gnt_i & data_err_i;
  assign load_err_o  = gnt_err & ~req_we;
  assign store_err_o = gnt_err &  req_we;

endmodule

// File: tb/lsu_sva.sv
`timescale 1ns/100ps

module lsu_sva
  import lsu_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input logic            req_i,          // execute stage request
  input logic            ready_i,
  input logic            valid_i,
  input logic            data_req_i,
  input logic            data_gnt_i,
  input logic            data_rvalid_i,
  input logic [XLEN-1:0] data_addr_i,
  input logic            data_we_i,
  input logic [BE_W-1:0] data_be_i,
  input logic [XLEN-1:0] data_wdata_i
);

  int   fail_count = 0;  // failed assertions so far
  logic pending_q;       // granted, response not yet back

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q <= 1'b0;
    end
    else if (data_req_i && data_gnt_i)
    begin
      pending_q <= 1'b1;
    end
    else if (data_rvalid_i)
    begin
      pending_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) && $stable(data_we_i)
      && $stable(data_be_i) && $stable(data_wdata_i))
  else
  begin
    $error("memory request dropped or changed before its grant");
    fail_count++;
  end

  // one transaction in flight at most
  no_req_pending: assert property (@(posedge clk) disable iff (!rst_n)
    pending_q |-> !data_req_i)
  else
  begin
    $error("memory request raised while a response is pending");
    fail_count++;
  end

  req_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(data_req_i))
  else
  begin
    $error("data_req_o is unknown");
    fail_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // execute side
  //////////////////////////////////////////////////////////////////////

  ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && ready_i |=> !ready_i)
  else
  begin
    $error("ready_o still high after acceptance");
    fail_count++;
  end

  ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !ready_i && !valid_i |=> !ready_i)
  else
  begin
    $error("ready_o rose before valid_o");
    fail_count++;
  end

  ready_back: assert property (@(posedge clk) disable iff (!rst_n) valid_i |=> ready_i)
  else
  begin
    $error("ready_o low in the cycle after valid_o");
    fail_count++;
  end

endmodule

bind lsu_top lsu_sva u_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .req_i         (req_i),
  .ready_i       (ready_o),
  .valid_i       (valid_o),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_addr_i   (data_addr_o),
  .data_we_i     (data_we_o),
  .data_be_i     (data_be_o),
  .data_wdata_i  (data_wdata_o)
);

// File: tb/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu
  import lsu_pkg::*;
();

  localparam int N_RAND     = 150;                 // random operations
  localparam int N_OPS      = 12 * 4 + N_RAND * 3;  // upper bound, readbacks included
  localparam int MAX_CYCLES = N_OPS * 16 + 100;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            req_i;
  logic            we_i;
  mem_size_e       size_i;
  logic            sign_ext_i;
  logic [XLEN-1:0] addr_i;
  logic [XLEN-1:0] wdata_i;
  logic            ready_o;
  logic            valid_o;
  logic [XLEN-1:0] rdata_o;
  logic            busy_o;
  logic            data_req_o;
  logic            data_gnt_i;
  logic            data_rvalid_i;
  logic            data_err_i;
  logic [XLEN-1:0] data_addr_o;
  logic            data_we_o;
  logic [BE_W-1:0] data_be_o;
  logic [XLEN-1:0] data_wdata_o;
  logic [XLEN-1:0] data_rdata_i;
  logic            load_err_o;
  logic            store_err_o;

  logic [XLEN-1:0] mem [16];      // memory model, address bits 5:2
  logic [7:0]      shadow [64];   // byte view for predictions
  int unsigned     gnt_count;     // grants in the current operation
  logic [XLEN-1:0] gnt_addr [2];
  logic            cur_we = 1'b0; // direction of the operation in flight
  int unsigned     cycle_count = 0;

  always #50 clk = ~clk;  // 100 ns period

  lsu_top UUT (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic ok, input string msg);
    assert (ok)
    else
    begin
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic int size_bytes(input mem_size_e sz);
    case (sz)
      SIZE_WORD: return 4;
      SIZE_HALF: return 2;
      default:   return 1;
    endcase
  endfunction

  // bytes from the shadow, little endian, then extension
  function automatic logic [XLEN-1:0] predict_load(input mem_size_e sz, input logic sx,
                                                   input logic [5:0] a);
    logic [XLEN-1:0] v;
    int              n;
    v = '0;
    n = size_bytes(sz);
    for (int k = 0; k < BE_W; k++)
    begin
      if (k < n)
        v[8*k +: 8] = shadow[6'(a + k)];  // wraps past the last word
      else if (sx && v[8*n-1])
        v[8*k +: 8] = 8'hff;
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  task automatic serve_request();
    int unsigned gnt_delay;
    int unsigned rsp_delay;
    logic        err;
    logic [3:0]  idx;
    gnt_delay = $urandom_range(3, 0);
    rsp_delay = $urandom_range(3, 1);
    err       = ($urandom_range(7, 0) == 0);  // about one grant in eight
    repeat (gnt_delay) @(negedge clk);
    idx        = data_addr_o[5:2];
    data_gnt_i = 1'b1;
    data_err_i = err;
    if (gnt_count < 2)
      gnt_addr[gnt_count] = data_addr_o;
    gnt_count++;
    for (int b = 0; b < BE_W; b++)
      if (data_we_o && data_be_o[b])
        mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];  // write under the enables
    #20;
    check(data_we_o == cur_we,
          $sformatf("data_we_o %b on grant, expected %b", data_we_o, cur_we));
    check(load_err_o == (err && !cur_we) && store_err_o == (err && cur_we),
          $sformatf("error flags load %b store %b on grant, err %b we %b",
                    load_err_o, store_err_o, err, cur_we));
    @(negedge clk);
    data_gnt_i = 1'b0;
    data_err_i = 1'b0;
    repeat (rsp_delay - 1) @(negedge clk);
    data_rvalid_i = 1'b1;
    data_rdata_i  = mem[idx];
  endtask

  initial
  begin
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    forever
    begin
      @(negedge clk);
      data_rvalid_i = 1'b0;  // response lasts one cycle
      if (rst_n && data_req_o)
        serve_request();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////////////////////////

  task automatic run_op(input logic op_we, input mem_size_e op_size, input logic op_sext,
                        input logic [5:0] op_addr, input logic [XLEN-1:0] op_wdata);
    logic [XLEN-1:0] expected;
    logic            split;
    expected = predict_load(op_size, op_sext, op_addr);
    split    = (int'(op_addr[1:0]) + size_bytes(op_size)) > BE_W;
    @(negedge clk);
    gnt_count  = 0;
    cur_we     = op_we;
    req_i      = 1'b1;
    we_i       = op_we;
    size_i     = op_size;
    sign_ext_i = op_sext;
    addr_i     = XLEN'(op_addr);
    wdata_i    = op_wdata;
    #20;
    check(ready_o && !busy_o, "ready_o low or busy_o high while the unit is idle");
    @(negedge clk);  // accepted on the edge in between
    req_i   = 1'b0;
    addr_i  = $urandom;  // captured already
    wdata_i = $urandom;
    do
    begin
      @(negedge clk);
      #20;
      check(busy_o, "busy_o low while an access is in flight");
    end
    while (!valid_o);
    check(gnt_count == (split ? 2 : 1),
          $sformatf("%0d transactions for %s at %h", gnt_count, op_size.name(), op_addr));
    check(gnt_addr[0] == XLEN'(op_addr), $sformatf("first address %h", gnt_addr[0]));
    if (split)
      check(gnt_addr[1] == XLEN'({op_addr[5:2], 2'b00}) + 4,
            $sformatf("second address %h for %h", gnt_addr[1], op_addr));
    if (op_we)
      for (int k = 0; k < size_bytes(op_size); k++)
        shadow[6'(op_addr + k)] = op_wdata[8*k +: 8];
    else
      check(rdata_o == expected, $sformatf("load %s at %h sext %b: got %h, expected %h",
                                           op_size.name(), op_addr, op_sext, rdata_o, expected));
  endtask

  // store, then word loads of every word it touched
  task automatic store_and_readback(input mem_size_e sz, input logic [5:0] a,
                                    input logic [XLEN-1:0] d);
    run_op(1'b1, sz, 1'b0, a, d);
    run_op(1'b0, SIZE_WORD, 1'b0, {a[5:2], 2'b00}, '0);
    if (int'(a[1:0]) + size_bytes(sz) > BE_W)
      run_op(1'b0, SIZE_WORD, 1'b0, {a[5:2] + 4'd1, 2'b00}, '0);  // spilled word
  endtask

  always @(negedge clk)
  begin
    cycle_count++;
    if (UUT.u_sva.fail_count != 0)
    begin
      $display("a protocol assertion failed at %0t ns", $time);
      $display("RESULT: FAIL");
      $fatal(1, "protocol violation");
    end
    else if (cycle_count >= MAX_CYCLES)
    begin
      $display("the run timed out after %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    mem_size_e  r_size;
    logic [5:0] r_addr;
    void'($urandom(61132));
    rst_n      = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    size_i     = SIZE_WORD;
    sign_ext_i = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    for (int i = 0; i < 16; i++)
    begin
      mem[i] = $urandom;
      for (int b = 0; b < BE_W; b++)
        shadow[4*i+b] = mem[i][8*b +: 8];
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    #20;
    check(ready_o && !valid_o && !data_req_o && !load_err_o && !store_err_o,
          "outputs wrong after reset");

    // every size at every offset
    for (int s = 0; s < 3; s++)
      for (int off = 0; off < BE_W; off++)
      begin
        r_addr = {4'($urandom), 2'(off)};
        store_and_readback(mem_size_e'(2'(s)), r_addr, $urandom);
        run_op(1'b0, mem_size_e'(2'(s)), 1'($urandom), r_addr, '0);
      end

    for (int i = 0; i < N_RAND; i++)
    begin
      r_size = mem_size_e'(2'($urandom_range(2, 0)));
      r_addr = 6'($urandom);
      if ($urandom_range(1, 0))
        store_and_readback(r_size, r_addr, $urandom);
      else
        run_op(1'b0, r_size, 1'($urandom), r_addr, '0);
    end

    repeat (2) @(negedge clk);
    if (UUT.u_sva.fail_count == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("protocol assertions failed during the run");
      $display("RESULT: FAIL");
      $fatal(1, "protocol violation");
    end
  end

endmodule

// File: src.f
logic/lsu_pkg.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_req_regs.sv
logic/lsu_store_path.sv
logic/lsu_load_path.sv
logic/lsu_top.sv
tb/lsu_sva.sv
tb/tb_lsu.sv
